// File: src.f
common/fpga_subsys_pkg.sv
spi/spi_slave.sv
verilog/reg_file.sv
verilog/tick_gen.sv
servo/servo_pwm.sv
verilog/fpga_subsys_top.sv
test/fpga_subsys_checker.sv
test/tb_fpga_subsys.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, then scan the log for the result
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_fpga_subsys -f src.f > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/Vtb_fpga_subsys +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

grep -q "Verification failed" sim.log && exit 1
grep -q "Verification passed" sim.log || { echo "Simulation ended without a result"; exit 1; }
exit 0

// File: test/tb_fpga_subsys.sv
/* Testbench of the FPGA subsystem: clock, reset, SPI master tasks,
   register read-back, servo and LED stimulus, timeout and result */
`timescale 1ns/1ps
`default_nettype none

module tb_fpga_subsys;

    localparam int tick_div   = 4;                      // Short ticks for simulation
    localparam int half_clks  = 8;                      // Clocks per SPI half period
    localparam int period_clk = 256 * tick_div;         // Clocks per servo period
    localparam int max_cycles = 40000;                  // About twice the sequence

    logic                   clock;
    logic                   reset_n;
    logic                   spi_clock;
    logic                   cs_n;
    logic                   mosi;
    logic [3:0]             motor_fault;
    logic                   miso;
    logic [3:0]             servo_pwm;
    logic                   status_fault;
    logic                   status_pi;
    logic                   status_ps4;
    logic                   status_debug;
    int                     read_errors;                // Read-back mismatches
    int                     cycle_count;                // Watchdog count
    integer                 seed;
    fpga_subsys_pkg::data_t pos_val [4];                // Written ratios
    fpga_subsys_pkg::data_t led_val;
    logic [3:0]             fault_val;

    fpga_subsys_top #(
        .TICK_DIV (tick_div)
    ) DUT (
        .clock        (clock),
        .reset_n      (reset_n),
        .spi_clock    (spi_clock),
        .cs_n         (cs_n),
        .mosi         (mosi),
        .motor_fault  (motor_fault),
        .miso         (miso),
        .servo_pwm    (servo_pwm),
        .status_fault (status_fault),
        .status_pi    (status_pi),
        .status_ps4   (status_ps4),
        .status_debug (status_debug)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;                     // 100 ns period
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (cycle_count >= max_cycles);
        $display("Timeout after %0d cycles, test sequence did not finish", max_cycles);
        $display("Verification failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // SPI master, mode 0, MSB first
    ////////////////////////////////////////////////////////////
    task automatic spi_transfer(input fpga_subsys_pkg::data_t cmd_byte,
                                input fpga_subsys_pkg::data_t data_byte,
                                output fpga_subsys_pkg::data_t rx_byte);
        logic [15:0] frame;
        frame   = {cmd_byte, data_byte};
        rx_byte = '0;
        @(posedge clock);
        cs_n <= 1'b0;
        repeat (half_clks) @(posedge clock);
        for (int i = 15; i >= 0; i--) begin
            spi_clock <= 1'b0;                          // Falling edge, next bit out
            mosi      <= frame[i];
            repeat (half_clks) @(posedge clock);
            spi_clock <= 1'b1;                          // Rising edge, both sides sample
            if (i < 8) begin
                rx_byte = {rx_byte[6:0], miso};
            end
            repeat (half_clks) @(posedge clock);
        end
        spi_clock <= 1'b0;
        repeat (half_clks) @(posedge clock);
        cs_n <= 1'b1;
        mosi <= 1'b0;
        repeat (half_clks) @(posedge clock);            // Gap between frames
    endtask

    task automatic reg_write(input fpga_subsys_pkg::addr_t addr,
                             input fpga_subsys_pkg::data_t data);
        fpga_subsys_pkg::data_t unused;
        spi_transfer({1'b1, 1'b0, addr}, data, unused);
    endtask

    // Byte 2 carries junk that the slave must ignore
    task automatic check_read(input fpga_subsys_pkg::addr_t addr,
                              input fpga_subsys_pkg::data_t expected, input string name);
        fpga_subsys_pkg::data_t got;
        spi_transfer({1'b0, 1'b0, addr}, 8'($random(seed)), got);
        if (got !== expected) begin
            read_errors++;
            $display("Mismatch at %0t ns: %s expected 8'h%02h, actual 8'h%02h",
                     $time, name, expected, got);
        end
    endtask

    task automatic fault_check(input int rounds);
        for (int n = 0; n < rounds; n++) begin
            fault_val = 4'($random(seed));
            @(posedge clock);
            motor_fault <= fault_val;
            check_read(fpga_subsys_pkg::reg_fault, {4'h0, fault_val}, "reg_fault");
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////
    initial begin
        seed        = 32'hce279147;
        read_errors = 0;
        cycle_count = 0;
        reset_n     = 1'b0;
        spi_clock   = 1'b0;
        cs_n        = 1'b1;
        mosi        = 1'b0;
        motor_fault = 4'h0;
        repeat (3) @(posedge clock);
        reset_n <= 1'b1;

        // Register write and read-back
        for (int i = 0; i < 4; i++) begin
            pos_val[i] = 8'($random(seed));
            reg_write(fpga_subsys_pkg::addr_t'(fpga_subsys_pkg::reg_servo_pos0 + i), pos_val[i]);
        end
        led_val = 8'($random(seed));
        reg_write(fpga_subsys_pkg::reg_status_led, led_val);
        for (int i = 0; i < 4; i++) begin
            check_read(fpga_subsys_pkg::addr_t'(fpga_subsys_pkg::reg_servo_pos0 + i),
                       pos_val[i], $sformatf("reg_servo_pos%0d", i));
        end
        check_read(fpga_subsys_pkg::reg_status_led, led_val, "reg_status_led");
        check_read(fpga_subsys_pkg::reg_id, 8'hA5, "reg_id");
        reg_write(fpga_subsys_pkg::reg_id, 8'h3C);      // Read only, must be dropped
        check_read(fpga_subsys_pkg::reg_id, 8'hA5, "reg_id");
        check_read(6'h2A, 8'h00, "unmapped 0x2a");

        // Servo channels 0 to 2 on, channel 3 off
        reg_write(fpga_subsys_pkg::reg_servo_pos0, 8'hC0);
        reg_write(fpga_subsys_pkg::reg_servo_ctrl, 8'h07);
        check_read(fpga_subsys_pkg::reg_servo_ctrl, 8'h07, "reg_servo_ctrl");
        repeat (3 * period_clk) @(posedge clock);

        // Ratio changes inside a pulse wait for the next boundary
        @(posedge servo_pwm[0]);
        reg_write(fpga_subsys_pkg::reg_servo_pos0, 8'h20);
        reg_write(fpga_subsys_pkg::reg_servo_pos1, 8'h00);
        reg_write(fpga_subsys_pkg::reg_servo_ctrl, 8'h03);
        repeat (2 * period_clk) @(posedge clock);

        // Fault inputs in normal mode, then in lamp test
        fault_check(6);
        reg_write(fpga_subsys_pkg::reg_servo_ctrl, 8'h13);
        for (int n = 0; n < 4; n++) begin
            reg_write(fpga_subsys_pkg::reg_status_led, 8'($random(seed)));
            fault_check(1);
        end
        reg_write(fpga_subsys_pkg::reg_servo_ctrl, 8'h03);
        fault_check(2);

        $display("Errors: %0d read-back mismatches, %0d assertion failures",
                 read_errors, DUT.u_checker.fail_count);
        if (read_errors == 0 && DUT.u_checker.fail_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/fpga_subsys_checker.sv
/* Concurrent assertions on reset values, servo PWM high time
   and status LEDs, bound to the top level */
`timescale 1ns/1ps
`default_nettype none

module fpga_subsys_checker #(
    parameter int TICK_DIV = 1024                       // Clocks per servo tick
) (
    input wire                              clock,
    input wire                              reset_n,
    input wire fpga_subsys_pkg::reg_req_t   req,        // Register access strobes
    input wire                              tick,       // Servo tick
    input wire [3:0]                        motor_fault,
    input wire                              miso,
    input wire [3:0]                        servo_pwm,
    input wire                              status_fault,
    input wire                              status_pi,
    input wire                              status_ps4,
    input wire                              status_debug
);

    int                                 fail_count = 0; // Failed assertions, read by the TB
    fpga_subsys_pkg::data_t             ctrl_q;         // Model of reg_servo_ctrl
    fpga_subsys_pkg::data_t             led_q;          // Model of reg_status_led
    fpga_subsys_pkg::data_t [3:0]       pos_q;          // Model of the position regs
    logic [7:0]                         period_cnt;     // Ticks into the servo period
    fpga_subsys_pkg::data_t [3:0]       ratio_act;      // Ratio of the period in progress
    logic [3:0]                         en_act;         // Enable of the period in progress
    int                                 high_cnt [4];   // High clocks seen this period
    logic                               boundary;       // Last tick of a period
    logic                               lamp;           // Lamp test mode

    assign boundary = tick && (period_cnt == 8'hff);
    assign lamp     = ctrl_q[4];

    ////////////////////////////////////////////////////////////
    // Register model and PWM high-time counters
    ////////////////////////////////////////////////////////////
    always @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            ctrl_q     <= '0;
            led_q      <= '0;
            pos_q      <= '0;
            period_cnt <= '0;
            ratio_act  <= '0;
            en_act     <= '0;
            for (int i = 0; i < 4; i++) begin
                high_cnt[i] <= 0;
            end
        end else begin
            if (req.wr_en) begin
                case (req.addr)
                    fpga_subsys_pkg::reg_servo_ctrl: ctrl_q   <= req.wdata;
                    fpga_subsys_pkg::reg_servo_pos0: pos_q[0] <= req.wdata;
                    fpga_subsys_pkg::reg_servo_pos1: pos_q[1] <= req.wdata;
                    fpga_subsys_pkg::reg_servo_pos2: pos_q[2] <= req.wdata;
                    fpga_subsys_pkg::reg_servo_pos3: pos_q[3] <= req.wdata;
                    fpga_subsys_pkg::reg_status_led: led_q    <= req.wdata;
                    default: ;                          // Read only or unmapped
                endcase
            end
            if (tick) begin
                period_cnt <= period_cnt + 8'd1;        // 256 ticks per period
            end
            for (int i = 0; i < 4; i++) begin
                if (boundary) begin                     // New period, new settings
                    high_cnt[i]  <= 0;
                    ratio_act[i] <= pos_q[i];
                    en_act[i]    <= ctrl_q[i];
                end else begin
                    high_cnt[i] <= high_cnt[i] + int'(servo_pwm[i]);
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Assertions
    ////////////////////////////////////////////////////////////
    a_reset_values: assert property (@(posedge clock)
        $rose(reset_n) |-> (servo_pwm == 4'h0) && !miso && !status_pi && !status_ps4
                           && status_debug)
    else begin
        fail_count++;
        $error("Outputs not at their reset values after reset");
    end

    // Each period holds exactly ratio x TICK_DIV high clocks
    for (genvar i = 0; i < 4; i++) begin : g_chan
        a_high_time: assert property (@(posedge clock) disable iff (!reset_n)
            boundary |-> (high_cnt[i] + int'(servo_pwm[i])) ==
                         (en_act[i] ? int'(ratio_act[i]) * TICK_DIV : 0))
        else begin
            fail_count++;
            $error("Servo channel %0d high time wrong in the period just ended", i);
        end
    end

    a_led_fault: assert property (@(posedge clock) disable iff (!reset_n)
        status_fault == (lamp ? led_q[2] : |motor_fault))
    else begin
        fail_count++;
        $error("Fault LED does not follow the LED rule");
    end

    a_led_links: assert property (@(posedge clock) disable iff (!reset_n)
        (status_pi == (lamp | led_q[0])) && (status_ps4 == (lamp | led_q[1])))
    else begin
        fail_count++;
        $error("Host or gamepad LED does not follow the LED rule");
    end

    a_led_debug: assert property (@(posedge clock) disable iff (!reset_n)
        status_debug == (lamp ? led_q[3] : 1'b1))
    else begin
        fail_count++;
        $error("Debug LED does not follow the LED rule");
    end

endmodule

bind fpga_subsys_top fpga_subsys_checker #(
    .TICK_DIV (TICK_DIV)
) u_checker (
    .clock        (clock),
    .reset_n      (reset_n),
    .req          (req),
    .tick         (tick),
    .motor_fault  (motor_fault),
    .miso         (miso),
    .servo_pwm    (servo_pwm),
    .status_fault (status_fault),
    .status_pi    (status_pi),
    .status_ps4   (status_ps4),
    .status_debug (status_debug)
);

`default_nettype wire

// File: verilog/fpga_subsys_top.sv
/* Top level of the FPGA subsystem: SPI slave, register file,
   tick generator and four servo PWM channels */
`timescale 1ns/1ps
`default_nettype none

module fpga_subsys_top #(
    parameter int TICK_DIV = 1024                       // Clocks per servo tick
) (
    input  wire        clock,                           // System clock
    input  wire        reset_n,                         // Async reset, active low
    input  wire        spi_clock,                       // SPI clock
    input  wire        cs_n,                            // SPI chip select
    input  wire        mosi,                            // SPI data in
    input  wire  [3:0] motor_fault,                     // Rotation motor faults
    output wire        miso,                            // SPI data out
    output wire  [3:0] servo_pwm,                       // Servo PWM waves
    output wire        status_fault,                    // Fault LED
    output wire        status_pi,                       // Host connected LED
    output wire        status_ps4,                      // Gamepad connected LED
    output wire        status_debug                     // Debug LED
);

    fpga_subsys_pkg::reg_req_t                               req;         // SPI access
    fpga_subsys_pkg::data_t                                  rdata;       // Read value
    logic                                                    tick;        // Servo tick
    logic [fpga_subsys_pkg::num_servo-1:0]                   servo_en;    // Enables
    fpga_subsys_pkg::data_t [fpga_subsys_pkg::num_servo-1:0] servo_ratio; // Ratios

    spi_slave u_spi (
        .clock     (clock),
        .reset_n   (reset_n),
        .spi_clock (spi_clock),
        .cs_n      (cs_n),
        .mosi      (mosi),
        .rdata     (rdata),
        .miso      (miso),
        .req       (req)
    );

    reg_file u_regs (
        .clock        (clock),
        .reset_n      (reset_n),
        .req          (req),
        .motor_fault  (motor_fault),
        .rdata        (rdata),
        .servo_en     (servo_en),
        .servo_ratio  (servo_ratio),
        .status_fault (status_fault),
        .status_pi    (status_pi),
        .status_ps4   (status_ps4),
        .status_debug (status_debug)
    );

    tick_gen #(
        .TICK_DIV (TICK_DIV)
    ) u_tick (
        .clock   (clock),
        .reset_n (reset_n),
        .tick    (tick)
    );

    ////////////////////////////////////////////////////////////
    // Servo channels
    ////////////////////////////////////////////////////////////
    for (genvar i = 0; i < fpga_subsys_pkg::num_servo; i++) begin : g_servo
        servo_pwm u_pwm (
            .clock   (clock),
            .reset_n (reset_n),
            .tick    (tick),
            .enable  (servo_en[i]),
            .ratio   (servo_ratio[i]),
            .pwm_out (servo_pwm[i])
        );
    end

endmodule

`default_nettype wire

// File: servo/servo_pwm.sv
/* One servo PWM channel, 256 ticks per period, with ratio and enable
   taken at the period boundary */
`timescale 1ns/1ps
`default_nettype none

module servo_pwm (
    input  wire                          clock,     // System clock
    input  wire                          reset_n,   // Async reset, active low
    input  wire                          tick,      // Period step enable
    input  wire                          enable,    // Requested channel enable
    input  wire fpga_subsys_pkg::data_t  ratio,     // Requested high ticks
    output logic                         pwm_out    // Servo PWM wave
);

    logic [7:0]              period_cnt;            // Ticks into the period
    fpga_subsys_pkg::data_t  ratio_q;               // Active ratio
    logic                    enable_q;              // Active enable

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            period_cnt <= '0;
            ratio_q    <= '0;
            enable_q   <= 1'b0;
            pwm_out    <= 1'b0;
        end else begin
            if (tick) begin
                period_cnt <= period_cnt + 8'd1;    // Wraps to 0 after 255
                if (period_cnt == 8'hff) begin      // Period boundary
                    ratio_q  <= ratio;
                    enable_q <= enable;
                end
            end
            pwm_out <= enable_q && (period_cnt < ratio_q); // First ratio ticks high
        end
    end

endmodule

`default_nettype wire

// File: verilog/tick_gen.sv
/* Clock divider producing a one-cycle tick every TICK_DIV clocks */
`timescale 1ns/1ps
`default_nettype none

module tick_gen #(
    parameter int TICK_DIV = 1024                       // Clocks per tick
) (
    input  wire  clock,                                 // System clock
    input  wire  reset_n,                               // Async reset, active low
    output logic tick                                   // One clock high per period
);

    localparam int cnt_w = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [cnt_w-1:0] div_cnt;                          // Divider count
    logic             wrap;                             // Last count of the period

    assign wrap = (div_cnt == cnt_w'(TICK_DIV - 1));

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            div_cnt <= '0;
            tick    <= 1'b0;
        end else begin
            div_cnt <= wrap ? '0 : div_cnt + 1'b1;
            tick    <= wrap;                            // Pulse on the wrap
        end
    end

endmodule

`default_nettype wire

// File: verilog/reg_file.sv
/* Register storage, address decode, read mux and status-LED
   multiplexing with lamp test */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire                                 clock,          // System clock
    input  wire                                 reset_n,        // Async reset, active low
    input  wire fpga_subsys_pkg::reg_req_t      req,            // Access from SPI
    input  wire [3:0]                           motor_fault,    // Rotation motor faults
    output fpga_subsys_pkg::data_t              rdata,          // Read value of req.addr
    output logic [fpga_subsys_pkg::num_servo-1:0] servo_en,     // Channel enables
    output fpga_subsys_pkg::data_t [fpga_subsys_pkg::num_servo-1:0] servo_ratio,
    output logic                                status_fault,   // Fault LED
    output logic                                status_pi,      // Host connected LED
    output logic                                status_ps4,     // Gamepad connected LED
    output logic                                status_debug    // Debug LED
);

    fpga_subsys_pkg::data_t                                 servo_ctrl;  // Enables, LED test
    fpga_subsys_pkg::data_t [fpga_subsys_pkg::num_servo-1:0] servo_pos;  // Channel ratios
    fpga_subsys_pkg::data_t                                 status_led;  // LED control bits
    logic                                                   led_test;    // Lamp test mode

    ////////////////////////////////////////////////////////////
    // Register writes
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            servo_ctrl <= '0;
            servo_pos  <= '0;
            status_led <= '0;
        end else if (req.wr_en) begin
            if (req.addr == fpga_subsys_pkg::reg_servo_ctrl) begin
                servo_ctrl <= req.wdata;
            end
            if (req.addr == fpga_subsys_pkg::reg_status_led) begin
                status_led <= req.wdata;
            end
            for (int i = 0; i < fpga_subsys_pkg::num_servo; i++) begin
                if (req.addr == fpga_subsys_pkg::addr_t'(fpga_subsys_pkg::reg_servo_pos0 + i))
                begin
                    servo_pos[i] <= req.wdata;          // Consecutive position regs
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Read mux
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (req.addr)
            fpga_subsys_pkg::reg_servo_ctrl: rdata = servo_ctrl;
            fpga_subsys_pkg::reg_servo_pos0: rdata = servo_pos[0];
            fpga_subsys_pkg::reg_servo_pos1: rdata = servo_pos[1];
            fpga_subsys_pkg::reg_servo_pos2: rdata = servo_pos[2];
            fpga_subsys_pkg::reg_servo_pos3: rdata = servo_pos[3];
            fpga_subsys_pkg::reg_status_led: rdata = status_led;
            fpga_subsys_pkg::reg_fault:
                rdata = {{(fpga_subsys_pkg::data_w-4){1'b0}}, motor_fault}; // Live inputs
            fpga_subsys_pkg::reg_id:         rdata = fpga_subsys_pkg::subsys_id;
            default:                         rdata = '0;  // Unmapped
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Servo controls and status LEDs
    ////////////////////////////////////////////////////////////
    assign servo_en    = servo_ctrl[fpga_subsys_pkg::num_servo-1:0];
    assign servo_ratio = servo_pos;
    assign led_test    = servo_ctrl[4];

    assign status_fault = led_test ? status_led[2] : |motor_fault;  // fault_led or any fault
    assign status_pi    = led_test ? 1'b1          : status_led[0]; // pi_connected
    assign status_ps4   = led_test ? 1'b1          : status_led[1]; // ps4_connected
    assign status_debug = led_test ? status_led[3] : 1'b1;          // motor_hot in test

endmodule

`default_nettype wire

// File: spi/spi_slave.sv
/* SPI mode-0 slave: pin synchronizers, edge detect, 16-bit framing,
   register request strobes and the read-data transmit shifter */
`timescale 1ns/1ps
`default_nettype none

module spi_slave (
    input  wire                             clock,      // System clock
    input  wire                             reset_n,    // Async reset, active low
    input  wire                             spi_clock,  // SPI clock pin
    input  wire                             cs_n,       // Chip select pin
    input  wire                             mosi,       // Master out slave in
    input  wire fpga_subsys_pkg::data_t     rdata,      // Register read value
    output logic                            miso,       // Master in slave out
    output fpga_subsys_pkg::reg_req_t       req         // Register request
);

    logic [2:0]                   sclk_sync;   // Two sync flops plus edge delay
    logic [1:0]                   cs_sync;     // Chip select sync
    logic [1:0]                   mosi_sync;   // Data sync
    logic                         spi_rise;    // Sampling edge
    logic                         spi_fall;    // Shift-out edge
    logic                         selected;    // Transfer in progress
    logic [3:0]                   bit_cnt;     // Bits received in this frame
    fpga_subsys_pkg::spi_frame_u  frame;       // Receive shifter
    fpga_subsys_pkg::spi_frame_u  frame_nxt;   // Shifter with the new bit
    fpga_subsys_pkg::spi_cmd_t    cmd;         // Latched command byte
    fpga_subsys_pkg::data_t       tx_shift;    // Transmit shifter

    ////////////////////////////////////////////////////////////
    // Pin synchronizers and edge detect
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            sclk_sync <= '0;
            cs_sync   <= 2'b11;                             // Deselected
            mosi_sync <= '0;
        end else begin
            sclk_sync <= {sclk_sync[1:0], spi_clock};
            cs_sync   <= {cs_sync[0], cs_n};
            mosi_sync <= {mosi_sync[0], mosi};
        end
    end

    assign selected = ~cs_sync[1];
    assign spi_rise = selected & sclk_sync[1] & ~sclk_sync[2];
    assign spi_fall = selected & ~sclk_sync[1] & sclk_sync[2];

    // Next shifter value, MSB first
    always_comb begin
        frame_nxt.data = {frame.data[6:0], mosi_sync[1]};
    end

    ////////////////////////////////////////////////////////////
    // Framing and register requests
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            bit_cnt  <= '0;
            frame    <= '0;
            cmd      <= '0;
            tx_shift <= '0;
            miso     <= 1'b0;
            req      <= '0;
        end else begin
            req.wr_en <= 1'b0;                              // Strobes last one cycle
            req.rd_en <= 1'b0;
            if (!selected) begin                            // Abort partial frame
                bit_cnt  <= '0;
                tx_shift <= '0;
                miso     <= 1'b0;
            end else begin
                if (spi_rise) begin
                    bit_cnt <= bit_cnt + 4'd1;              // Wraps after 16 bits
                    frame   <= frame_nxt;
                    if (bit_cnt == 4'd7) begin              // Command byte complete
                        cmd       <= frame_nxt.cmd;
                        req.addr  <= frame_nxt.cmd.addr;
                        req.rd_en <= ~frame_nxt.cmd.write;
                    end
                    if (bit_cnt == 4'd15 && cmd.write) begin // Data byte complete
                        req.wr_en <= 1'b1;
                        req.addr  <= cmd.addr;
                        req.wdata <= frame_nxt.data;
                    end
                end
                if (req.rd_en) begin
                    tx_shift <= rdata;                      // Capture read value
                end else if (spi_fall) begin
                    miso     <= tx_shift[7];                // Drive next bit
                    tx_shift <= {tx_shift[6:0], 1'b0};
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: common/fpga_subsys_pkg.sv
/* Shared widths, register map, SPI frame types and the register
   request struct of the FPGA subsystem */
`default_nettype none

package fpga_subsys_pkg;

    ////////////////////////////////////////////////////////////
    // Widths and counts
    ////////////////////////////////////////////////////////////
    parameter int addr_w    = 6;                // Register address width
    parameter int data_w    = 8;                // Register data width
    parameter int num_servo = 4;                // Servo channels

    typedef logic [addr_w-1:0] addr_t;          // Register address
    typedef logic [data_w-1:0] data_t;          // Register data value

    ////////////////////////////////////////////////////////////
    // Register map
    ////////////////////////////////////////////////////////////
    localparam addr_t reg_servo_ctrl = 6'h00;   // [3:0] enables, [4] LED test
    localparam addr_t reg_servo_pos0 = 6'h01;   // Channel 0 ratio
    localparam addr_t reg_servo_pos1 = 6'h02;
    localparam addr_t reg_servo_pos2 = 6'h03;
    localparam addr_t reg_servo_pos3 = 6'h04;
    localparam addr_t reg_status_led = 6'h05;   // pi, ps4, fault, hot
    localparam addr_t reg_fault      = 6'h06;   // Live motor faults, read only
    localparam addr_t reg_id         = 6'h07;   // Subsystem ID, read only

    localparam data_t subsys_id = 8'hA5;        // Value returned by reg_id

    ////////////////////////////////////////////////////////////
    // SPI framing
    ////////////////////////////////////////////////////////////
    // Command byte, first on the wire
    typedef struct packed {
        logic  write;                           // 1 = write, 0 = read
        logic  rsvd;                            // Unused
        addr_t addr;                            // Target register
    } spi_cmd_t;

    // Receive shifter, command in byte 1 and data in byte 2
    typedef union packed {
        spi_cmd_t cmd;
        data_t    data;
    } spi_frame_u;

    // One-cycle register access from the SPI slave
    typedef struct packed {
        logic  wr_en;                           // Write strobe
        logic  rd_en;                           // Read strobe
        addr_t addr;                            // Register address
        data_t wdata;                           // Write data
    } reg_req_t;

endpackage

`default_nettype wire
